//--- common/smc_pkg.sv
// One chip select and a 32-bit data bus only; memory size and reset timing fixed at build time
`default_nettype none

package smc_pkg;

  // ----------------------------------------------------------
  // Bus widths and memory size
  // ----------------------------------------------------------
  localparam int SMC_ADDR_W    = 32;      // AHB and EMI address width
  localparam int SMC_DATA_W    = 32;      // Data width
  localparam int SMC_MEM_BYTES = 1024;    // At or above this gives ERROR

  // Reset timing, in hclk cycles
  localparam logic [3:0] SMC_TSETUP_RST  = 4'd1;
  localparam logic [3:0] SMC_TSTROBE_RST = 4'd2;

  // ----------------------------------------------------------
  // AHB codes
  // ----------------------------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  // ----------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------
  localparam logic [4:0] REG_TIMING = 5'h00;   // Setup and strobe
  localparam logic [4:0] REG_STATUS = 5'h04;   // Bit 0 busy, read only

  localparam int TIM_FIELD_W    = 4;           // Both timing fields
  localparam int TIM_SETUP_LSB  = 0;           // Bits 3:0, 0 to 15 cycles
  localparam int TIM_STROBE_LSB = 4;           // Bits 7:4, 0 reads as 1

endpackage

`default_nettype wire

//--- common/smc_req_if.sv
// One request in flight; request fields stay stable while req_valid is high, done lasts one cycle
`timescale 1ns/1ps
`default_nettype none

interface smc_req_if;
  import smc_pkg::*;

  // Request side, driven by the AHB slave
  logic                  req_valid;   // Held until done
  logic                  req_write;   // 1 write, 0 read
  logic [SMC_ADDR_W-1:0] req_addr;    // Byte address
  logic [2:0]            req_size;    // HSIZE code
  logic [SMC_DATA_W-1:0] req_wdata;   // Lanes as on hwdata

  // Response side, driven by the sequencer
  logic                  done;        // One-cycle completion pulse
  logic [SMC_DATA_W-1:0] rdata;       // Valid with done on reads

  modport ahb (
    output req_valid, req_write, req_addr, req_size, req_wdata,
    input  done, rdata
  );

  modport seq (
    input  req_valid, req_write, req_addr, req_size, req_wdata,
    output done, rdata
  );

endinterface

`default_nettype wire

//--- hw/smc_ahb_slave.sv
// Single transfers only, bursts run as separate beats; hready input must be the muxed bus ready
`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave (
  input  logic                           hclk,
  input  logic                           rst,
  input  logic [smc_pkg::SMC_ADDR_W-1:0] haddr,
  input  logic [1:0]                     htrans,
  input  logic                           hsel,
  input  logic                           hwrite,
  input  logic [2:0]                     hsize,
  input  logic [smc_pkg::SMC_DATA_W-1:0] hwdata,
  input  logic                           hready,
  output logic [smc_pkg::SMC_DATA_W-1:0] smc_hrdata,
  output logic                           smc_hready,
  output logic [1:0]                     smc_hresp,
  output logic                           smc_valid,
  smc_req_if.ahb                         req
);
  import smc_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_ERR1, S_ERR2} state_t;

  state_t                state;
  logic                  trans_ok;   // NONSEQ or SEQ
  logic                  accept;     // Address phase taken this cycle
  logic                  in_range;
  logic                  write_q;
  logic [2:0]            size_q;
  logic [SMC_ADDR_W-1:0] addr_q;
  logic [SMC_DATA_W-1:0] wdata_q;

  // ----------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------
  assign trans_ok = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  assign accept   = hsel && hready && smc_hready && trans_ok;   // Own data phase must be ending
  assign in_range = haddr < SMC_ADDR_W'(SMC_MEM_BYTES);

  // Ready low through the access, high again with done
  always_comb begin
    case (state)
      S_BUSY:  smc_hready = req.done;
      S_ERR1:  smc_hready = 1'b0;      // First error cycle
      default: smc_hready = 1'b1;
    endcase
  end

  assign smc_hresp  = (state == S_ERR1 || state == S_ERR2) ? HRESP_ERROR : HRESP_OKAY;
  assign smc_hrdata = req.rdata;       // Full word, master picks lanes

  always_ff @(posedge hclk) begin
    if (rst) begin
      state     <= S_IDLE;
      smc_valid <= 1'b0;
    end else begin
      smc_valid <= 1'b0;
      if (accept) begin
        if (in_range) begin
          state     <= S_BUSY;
          smc_valid <= 1'b1;           // Also marks first data-phase cycle
        end else begin
          state     <= S_ERR1;         // Never reaches the sequencer
        end
      end else begin
        case (state)
          S_BUSY:  if (req.done) state <= S_IDLE;
          S_ERR1:  state <= S_ERR2;
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // Request fields, stable from capture until done
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      size_q  <= hsize;
    end
    if (smc_valid) wdata_q <= hwdata;  // First data-phase cycle
  end

  // ----------------------------------------------------------
  // Request to the sequencer
  // ----------------------------------------------------------
  assign req.req_valid = (state == S_BUSY);
  assign req.req_write = write_q;
  assign req.req_addr  = addr_q;
  assign req.req_size  = size_q;
  assign req.req_wdata = smc_valid ? hwdata : wdata_q;   // Live bus data in the capture cycle

  // Error response comes as a low-ready cycle followed by a high-ready one
  a_err_second: assert property (@(posedge hclk) disable iff (rst)
    (smc_hresp == HRESP_ERROR && !smc_hready) |=> (smc_hresp == HRESP_ERROR && smc_hready));
  a_err_first: assert property (@(posedge hclk) disable iff (rst)
    (smc_hresp == HRESP_ERROR && smc_hready) |-> $past(smc_hresp == HRESP_ERROR && !smc_hready));

endmodule

`default_nettype wire

//--- hw/smc_apb_regs.sv
// APB on hclk with no wait states; only REG_TIMING is writable, a strobe of 0 is stored as 1
`timescale 1ns/1ps
`default_nettype none

module smc_apb_regs (
  input  logic                            hclk,
  input  logic                            rst,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [4:0]                      paddr,
  input  logic [31:0]                     pwdata,
  input  logic                            busy,
  output logic [31:0]                     prdata,
  output logic [smc_pkg::TIM_FIELD_W-1:0] tsetup,
  output logic [smc_pkg::TIM_FIELD_W-1:0] tstrobe
);
  import smc_pkg::*;

  logic                   timing_wr;   // Enable-phase write to REG_TIMING
  logic [TIM_FIELD_W-1:0] strobe_in;

  assign timing_wr = psel && penable && pwrite && (paddr == REG_TIMING);
  assign strobe_in = pwdata[TIM_STROBE_LSB +: TIM_FIELD_W];

  // ----------------------------------------------------------
  // Timing register
  // ----------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      tsetup  <= SMC_TSETUP_RST;
      tstrobe <= SMC_TSTROBE_RST;
    end else if (timing_wr) begin
      tsetup  <= pwdata[TIM_SETUP_LSB +: TIM_FIELD_W];
      tstrobe <= (strobe_in == '0) ? TIM_FIELD_W'(1) : strobe_in;   // Zero-width strobe not allowed
    end
  end

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  always_comb begin
    prdata = '0;                       // Unmapped offsets read zero
    if (psel) begin
      case (paddr)
        REG_TIMING: begin
          prdata[TIM_SETUP_LSB +: TIM_FIELD_W]  = tsetup;
          prdata[TIM_STROBE_LSB +: TIM_FIELD_W] = tstrobe;
        end
        REG_STATUS: prdata[0] = busy;  // Access in progress
        default:    prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/smc_veneer.sv
// One chip select, APB on hclk, no scan; rst is synchronous and active high
`timescale 1ns/1ps
`default_nettype none

module smc_veneer (
  input  logic        hclk,
  input  logic        rst,
  // AHB slave port
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  input  logic [31:0] data_smc,       // EMI read data
  // APB register port
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // AHB response
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  // EMI pins, strobes active low
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_wr,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe,
  output logic        smc_busy
);
  import smc_pkg::*;

  logic [TIM_FIELD_W-1:0] tsetup;
  logic [TIM_FIELD_W-1:0] tstrobe;

  smc_req_if req_bus ();              // Slave to sequencer

  // ----------------------------------------------------------
  // Input side, processing, output pins
  // ----------------------------------------------------------
  smc_ahb_slave u_ahb (
    .hclk, .rst, .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid,
    .req (req_bus.ahb)
  );

  smc_apb_regs u_regs (
    .hclk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy    (smc_busy),
    .prdata, .tsetup, .tstrobe
  );

  smc_access_seq u_seq (
    .hclk, .rst, .tsetup, .tstrobe, .data_smc,
    .req     (req_bus.seq),
    .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_we, .smc_n_wr, .smc_n_rd,
    .smc_n_ext_oe,
    .busy    (smc_busy)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the SMC testbench with Verilator, pass or fail taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_smc -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_smc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- smc_emi/smc_access_seq.sv
// Asynchronous SRAM timing only, no external wait; tstrobe must be at least 1, data returned unshifted
`timescale 1ns/1ps
`default_nettype none

module smc_access_seq (
  input  logic                            hclk,
  input  logic                            rst,
  input  logic [smc_pkg::TIM_FIELD_W-1:0] tsetup,
  input  logic [smc_pkg::TIM_FIELD_W-1:0] tstrobe,
  input  logic [smc_pkg::SMC_DATA_W-1:0]  data_smc,
  smc_req_if.seq                          req,
  output logic [smc_pkg::SMC_ADDR_W-1:0]  smc_addr,
  output logic [smc_pkg::SMC_DATA_W-1:0]  smc_data,
  output logic [3:0]                      smc_n_be,
  output logic                            smc_n_cs,
  output logic [3:0]                      smc_n_we,
  output logic                            smc_n_wr,
  output logic                            smc_n_rd,
  output logic                            smc_n_ext_oe,
  output logic                            busy
);
  import smc_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_STROBE, ST_HOLD} state_t;

  state_t                 state;
  logic [TIM_FIELD_W-1:0] cnt;           // Cycles left in current phase
  logic                   write_q;
  logic [SMC_DATA_W-1:0]  rdata_q;
  logic [3:0]             be_n_new;      // Byte enables of the incoming request
  logic                   take;          // Request accepted this cycle
  logic                   last_strobe;

  // Little-endian lane select
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] addr_lo);
    case (size)
      HSIZE_BYTE: lane_mask = 4'b0001 << addr_lo;
      HSIZE_HALF: lane_mask = addr_lo[1] ? 4'b1100 : 4'b0011;
      default:    lane_mask = 4'b1111;  // Word
    endcase
  endfunction

  assign be_n_new    = ~lane_mask(req.req_size, req.req_addr[1:0]);
  assign take        = (state == ST_IDLE) && req.req_valid;
  assign last_strobe = (state == ST_STROBE) && (cnt == '0);

  // ----------------------------------------------------------
  // FSM and control pins
  // ----------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state        <= ST_IDLE;
      cnt          <= '0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 4'hF;
      smc_n_we     <= 4'hF;
      smc_n_wr     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: if (req.req_valid) begin
          smc_n_cs     <= 1'b0;
          smc_n_be     <= be_n_new;
          smc_n_ext_oe <= ~req.req_write;   // Drive data bus on writes
          if (tsetup != '0) begin
            state <= ST_SETUP;
            cnt   <= tsetup - 1'b1;
          end else begin
            state    <= ST_STROBE;          // No setup, strobe with chip select
            cnt      <= tstrobe - 1'b1;
            smc_n_rd <= req.req_write;
            smc_n_wr <= ~req.req_write;
            smc_n_we <= req.req_write ? be_n_new : 4'hF;
          end
        end
        ST_SETUP: begin
          if (cnt == '0) begin
            state    <= ST_STROBE;
            cnt      <= tstrobe - 1'b1;
            smc_n_rd <= write_q;
            smc_n_wr <= ~write_q;
            smc_n_we <= write_q ? smc_n_be : 4'hF;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_STROBE: begin
          if (cnt == '0) begin
            state    <= ST_HOLD;            // Strobes rise, cs stays low
            smc_n_rd <= 1'b1;
            smc_n_wr <= 1'b1;
            smc_n_we <= 4'hF;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin                      // Hold
          state        <= ST_IDLE;
          smc_n_cs     <= 1'b1;
          smc_n_be     <= 4'hF;
          smc_n_ext_oe <= 1'b1;
        end
      endcase
    end
  end

  // Address, write data and read capture
  always_ff @(posedge hclk) begin
    if (take) begin
      smc_addr <= req.req_addr;
      write_q  <= req.req_write;
      if (req.req_write) smc_data <= req.req_wdata;
    end
    if (last_strobe && !write_q) rdata_q <= data_smc;   // Sampled at end of strobe
  end

  assign req.done  = (state == ST_HOLD);
  assign req.rdata = rdata_q;
  assign busy      = (state != ST_IDLE);

  a_strobe_excl: assert property (@(posedge hclk) disable iff (rst)
    !(!smc_n_rd && !smc_n_wr));
  a_strobe_cs: assert property (@(posedge hclk) disable iff (rst)
    (!smc_n_rd || !smc_n_wr || (smc_n_we != 4'hF)) |-> !smc_n_cs);

endmodule

`default_nettype wire

//--- test/emi_mem_model.sv
// Simulation only; decodes the low 1024 bytes, lane enables are latched 1 ns after the write strobe falls
`timescale 1ns/1ps
`default_nettype none

module emi_mem_model (
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic        smc_n_cs,
  input  logic [3:0]  smc_n_we,
  input  logic        smc_n_wr,
  input  logic        smc_n_rd,
  output logic [31:0] data_smc
);

  logic [7:0] mem [0:1023];
  logic [3:0] we_l;          // Lane enables of the current write strobe
  logic [9:0] base;          // Word-aligned byte address

  assign base     = {smc_addr[9:2], 2'b00};
  assign data_smc = (!smc_n_cs && !smc_n_rd) ?
                    {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]} : 32'h0;

  // Fill depends on every address bit
  initial begin
    we_l = 4'hF;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 8'((i * 37) ^ (i >> 8));
    end
  end

  always @(negedge smc_n_wr) begin
    #1 we_l = smc_n_we;      // Enables fall in the same step as the strobe
  end

  // Write completes on the rising strobe
  always @(posedge smc_n_wr) begin
    if (!smc_n_cs) begin
      for (int i = 0; i < 4; i++) begin
        if (!we_l[i]) mem[base + i] = smc_data[8*i +: 8];
      end
    end
    we_l = 4'hF;
  end

endmodule

`default_nettype wire

//--- test/tb_smc.sv
// Self-checking SMC testbench; the shadow starts at zero, so every word is written before it is read
`timescale 1ns/1ps
`default_nettype none

module tb_smc;
  import smc_pkg::*;

  localparam int         TIMEOUT_CYC = 64;     // Longest data phase is 32 cycles
  localparam logic [1:0] K_APB_WR    = 2'd0;
  localparam logic [1:0] K_APB_RD    = 2'd1;
  localparam logic [1:0] K_AHB_WR    = 2'd2;
  localparam logic [1:0] K_AHB_RD    = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] data;       // APB write data
    logic [31:0] exp_val;    // prdata for APB reads, hresp for AHB
  } row_t;

  logic        hclk, rst;
  logic [31:0] haddr, hwdata, data_smc, pwdata, prdata, smc_hrdata, smc_addr, smc_data;
  logic [1:0]  htrans, smc_hresp;
  logic [2:0]  hsize;
  logic [4:0]  paddr;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        hsel, hwrite, hready, psel, penable, pwrite;
  logic        smc_hready, smc_valid, smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  logic [7:0]  shadow [0:SMC_MEM_BYTES-1];   // Expected memory contents
  row_t        tbl[$];
  logic [15:0] lfsr;
  logic [3:0]  cur_setup;                    // Timing as last programmed
  logic [3:0]  cur_strobe;
  int          errors;
  int          tests;

  smc_veneer DUT (.*);

  emi_mem_model u_mem (
    .smc_addr, .smc_data, .smc_n_cs, .smc_n_we, .smc_n_wr, .smc_n_rd, .data_smc
  );

  initial begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;
  end

  initial begin                              // Global watchdog
    #1_000_000;
    $display("watchdog expired before the test sequence finished");
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois taps 16,14,13,11
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};             // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [9:0] a;
    a = {addr[9:2], 2'b00};
    shadow_word = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
  endfunction

  // Little endian, byte n of the transfer sits on lane addr[1:0]+n
  task automatic update_shadow(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] data);
    int lane;
    for (int b = 0; b < (1 << size); b++) begin
      lane = int'(addr[1:0]) + b;
      shadow[{addr[9:2], 2'b00} + lane] = data[8*lane +: 8];
    end
  endtask

  // Active-low lanes of one transfer, same lane rule as the shadow
  function automatic logic [3:0] byte_enables_n(input logic [31:0] addr,
                                                input logic [2:0] size);
    logic [3:0] lanes;
    lanes = '0;
    for (int b = 0; b < (1 << size); b++) begin
      lanes[int'(addr[1:0]) + b] = 1'b1;
    end
    byte_enables_n = ~lanes;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp_v);
    assert (got === exp_v) else begin
      $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp_v);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic add_row(input logic [1:0] kind, input logic [31:0] addr,
                         input logic [2:0] size, input logic [31:0] data,
                         input logic [31:0] exp_v);
    row_t r;
    r.kind    = kind;
    r.addr    = addr;
    r.size    = size;
    r.data    = data;
    r.exp_val = exp_v;
    tbl.push_back(r);
  endtask

  function automatic string kind_name(input logic [1:0] k);
    case (k)
      K_APB_WR: kind_name = "apb_wr";
      K_APB_RD: kind_name = "apb_rd";
      K_AHB_WR: kind_name = "ahb_wr";
      default:  kind_name = "ahb_rd";
    endcase
  endfunction

  // ----------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge hclk);                         // Setup phase
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge hclk);
    penable = 1'b1;
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge hclk);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(negedge hclk);
    penable = 1'b1;
    @(posedge hclk);
    data = prdata;                           // End of enable phase
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One transfer, pins sampled on each falling edge of the data phase
  task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] wdata, input logic [1:0] exp_resp);
    int   n;
    int   n_setup;
    int   n_strobe;
    logic strb, finished, cs_seen, strobe_seen, err_low, valid_seen;
    n = 0;
    n_setup = 0;
    n_strobe = 0;
    finished = 1'b0;
    cs_seen = 1'b0;
    strobe_seen = 1'b0;
    err_low = 1'b0;
    valid_seen = 1'b0;
    @(negedge hclk);                         // Address phase
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    @(negedge hclk);                         // First data-phase cycle
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    while (!finished && n < TIMEOUT_CYC) begin
      n++;
      strb = wr ? smc_n_wr : smc_n_rd;
      if (n == 1) valid_seen = smc_valid;
      if (!smc_n_cs && !cs_seen) begin       // First chip-select cycle
        check_equal("smc_n_be", 32'(smc_n_be), 32'(byte_enables_n(addr, size)));
        check_equal("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'(!wr));
        check_equal("smc_busy", 32'(smc_busy), 32'h1);
      end
      if (!smc_n_cs) cs_seen = 1'b1;
      if (!strb) begin
        n_strobe++;
        strobe_seen = 1'b1;
      end else if (!smc_n_cs && !strobe_seen) begin
        n_setup++;                           // cs low, strobe not yet
      end
      if (!smc_hready && smc_hresp == HRESP_ERROR) err_low = 1'b1;
      if (smc_hready) finished = 1'b1;
      else @(negedge hclk);
    end
    if (!finished) begin
      $display("timeout: smc_hready stayed low for %0d cycles, address 0x%h",
               TIMEOUT_CYC, addr);
      errors++;
    end else if (exp_resp == HRESP_ERROR) begin
      check_equal("smc_hresp", 32'(smc_hresp), 32'(HRESP_ERROR));
      check_true(err_low, "first error cycle did not show ERROR with smc_hready low");
      check_equal("data_phase_cycles", n, 32'd2);
      check_true(!cs_seen, "smc_n_cs fell for an out-of-range address");
      check_true(!valid_seen, "smc_valid pulsed for an out-of-range address");
    end else begin
      check_equal("smc_hresp", 32'(smc_hresp), 32'(HRESP_OKAY));
      check_equal("data_phase_cycles", n, 32'(cur_setup) + 32'(cur_strobe) + 32'd2);
      check_equal("setup_cycles", n_setup, 32'(cur_setup));
      check_equal("strobe_low_cycles", n_strobe, 32'(cur_strobe));
      check_true(valid_seen, "smc_valid did not pulse after the address phase");
      if (!wr) check_equal("smc_hrdata", smc_hrdata, shadow_word(addr));
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    row_t        r;
    logic [31:0] v;
    logic [31:0] rd;
    int          e0;
    rst = 1'b1;
    haddr = '0;
    htrans = HTRANS_IDLE;
    hsel = 1'b0;
    hwrite = 1'b0;
    hsize = HSIZE_WORD;
    hwdata = '0;
    hready = 1'b1;                           // Only slave on the bus
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    lfsr = 16'd77;
    errors = 0;
    tests = 0;
    cur_setup = 4'd1;
    cur_strobe = 4'd2;
    for (int i = 0; i < SMC_MEM_BYTES; i++) begin
      shadow[i] = 8'h00;
    end

    // Registers: reset value, read back, strobe 0 as 1, unmapped offsets
    add_row(K_APB_RD, 32'(REG_TIMING), HSIZE_WORD, 32'h0, 32'h21);
    add_row(K_APB_RD, 32'(REG_STATUS), HSIZE_WORD, 32'h0, 32'h0);
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'hA3, 32'h0);
    add_row(K_APB_RD, 32'(REG_TIMING), HSIZE_WORD, 32'h0, 32'hA3);
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'hFFFF_FF05, 32'h0);
    add_row(K_APB_RD, 32'(REG_TIMING), HSIZE_WORD, 32'h0, 32'h15);
    add_row(K_APB_WR, 32'h0C, HSIZE_WORD, 32'hFF, 32'h0);
    add_row(K_APB_RD, 32'h0C, HSIZE_WORD, 32'h0, 32'h0);
    add_row(K_APB_RD, 32'(REG_TIMING), HSIZE_WORD, 32'h0, 32'h15);   // Unmapped write ignored
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h21, 32'h0);
    // Word write and read back at random word addresses
    for (int k = 0; k < 4; k++) begin
      take_bits(8, v);
      add_row(K_AHB_WR, {22'h0, v[7:0], 2'b00}, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
      add_row(K_AHB_RD, {22'h0, v[7:0], 2'b00}, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    end
    add_row(K_AHB_WR, 32'h3FC, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));   // Last word
    add_row(K_AHB_RD, 32'h3FC, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    // Lane decode inside one word
    add_row(K_AHB_WR, 32'h100, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h101, HSIZE_BYTE, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h102, HSIZE_HALF, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_RD, 32'h100, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h204, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h207, HSIZE_BYTE, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h204, HSIZE_HALF, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_RD, 32'h204, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    // Other setup and strobe settings
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h32, 32'h0);
    add_row(K_AHB_WR, 32'h040, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_RD, 32'h040, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h51, 32'h0);
    add_row(K_AHB_RD, 32'h040, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h14, 32'h0);
    add_row(K_AHB_WR, 32'h101, HSIZE_BYTE, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_RD, 32'h100, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h05, 32'h0);   // Strobe used as 1
    add_row(K_AHB_RD, 32'h3FC, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_APB_WR, 32'(REG_TIMING), HSIZE_WORD, 32'h30, 32'h0);   // Strobe with chip select
    add_row(K_AHB_WR, 32'h0C0, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_WR, 32'h0C2, HSIZE_BYTE, 32'h0, 32'(HRESP_OKAY));
    add_row(K_AHB_RD, 32'h0C0, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));
    // Out of range, then a normal access again
    add_row(K_AHB_RD, 32'(SMC_MEM_BYTES), HSIZE_WORD, 32'h0, 32'(HRESP_ERROR));
    add_row(K_AHB_WR, 32'h7FC, HSIZE_WORD, 32'h0, 32'(HRESP_ERROR));
    add_row(K_AHB_RD, 32'hFFFF_FFFC, HSIZE_WORD, 32'h0, 32'(HRESP_ERROR));
    add_row(K_AHB_RD, 32'h204, HSIZE_WORD, 32'h0, 32'(HRESP_OKAY));

    repeat (3) @(negedge hclk);
    rst = 1'b0;
    @(negedge hclk);

    // Pins after reset
    e0 = errors;
    check_equal("smc_n_cs", 32'(smc_n_cs), 32'h1);
    check_equal("smc_n_rd", 32'(smc_n_rd), 32'h1);
    check_equal("smc_n_wr", 32'(smc_n_wr), 32'h1);
    check_equal("smc_n_we", 32'(smc_n_we), 32'hF);
    check_equal("smc_n_be", 32'(smc_n_be), 32'hF);
    check_equal("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'h1);
    check_equal("smc_hready", 32'(smc_hready), 32'h1);
    check_equal("smc_hresp", 32'(smc_hresp), 32'(HRESP_OKAY));
    check_equal("smc_busy", 32'(smc_busy), 32'h0);
    check_equal("smc_valid", 32'(smc_valid), 32'h0);
    $display("test %0d reset pins: %0d errors", tests, errors - e0);
    tests++;

    foreach (tbl[i]) begin
      r  = tbl[i];
      e0 = errors;
      case (r.kind)
        K_APB_WR: begin
          apb_write(r.addr[4:0], r.data);
          if (r.addr[4:0] == REG_TIMING) begin
            cur_setup  = r.data[3:0];
            cur_strobe = (r.data[7:4] == 4'd0) ? 4'd1 : r.data[7:4];
          end
        end
        K_APB_RD: begin
          apb_read(r.addr[4:0], rd);
          check_equal("prdata", rd, r.exp_val);
        end
        K_AHB_WR: begin
          take_bits(32, v);
          ahb_xfer(1'b1, r.addr, r.size, v, r.exp_val[1:0]);
          if (r.exp_val[1:0] == HRESP_OKAY) update_shadow(r.addr, r.size, v);
        end
        default: ahb_xfer(1'b0, r.addr, r.size, 32'h0, r.exp_val[1:0]);
      endcase
      $display("test %0d %s addr 0x%h: %0d errors", tests, kind_name(r.kind), r.addr,
               errors - e0);
      tests++;
    end

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/smc_pkg.sv
common/smc_req_if.sv
hw/smc_ahb_slave.sv
hw/smc_apb_regs.sv
smc_emi/smc_access_seq.sv
hw/smc_veneer.sv
test/emi_mem_model.sv
test/tb_smc.sv
